// File: design/isa_pkg.sv
`default_nettype none

package isa_pkg;

  localparam int data_w = 32;
  localparam int reg_w = 6;  // register 0 means no source
  localparam int imm_w = 16;

  typedef enum logic [2:0] {
    alu_add  = 3'd0,
    alu_sub  = 3'd1,
    alu_and  = 3'd2,
    alu_or   = 3'd3,
    alu_xor  = 3'd4,
    alu_addi = 3'd5
  } alu_op_e;

  // all arithmetic wraps at 2**data_w
  function automatic logic [data_w-1:0] alu_result(
    input alu_op_e           op,
    input logic [data_w-1:0] a,
    input logic [data_w-1:0] b,
    input logic [imm_w-1:0]  imm
  );
    logic [data_w-1:0] imm_ext;
    imm_ext = {{(data_w - imm_w){imm[imm_w-1]}}, imm};
    case (op)
      alu_add:  return a + b;
      alu_sub:  return a - b;
      alu_and:  return a & b;
      alu_or:   return a | b;
      alu_xor:  return a ^ b;
      alu_addi: return a + imm_ext;  // operand 2 not used
      default:  return '0;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: design/station_pkg.sv
`default_nettype none

package station_pkg;
  import isa_pkg::*;

  localparam int rs_depth = 16;
  localparam int space_w = 5;
  localparam logic [2:0] alu_station = 3'd1;

  typedef struct packed {
    logic              valid;
    logic [2:0]        station;  // target station selector
    alu_op_e           op;
    logic [reg_w-1:0]  src1;
    logic [reg_w-1:0]  src2;
    logic              ready1;
    logic              ready2;
    logic [data_w-1:0] data1;
    logic [data_w-1:0] data2;
    logic [imm_w-1:0]  imm;
    logic [reg_w-1:0]  dest_arn;
    logic [reg_w-1:0]  dest_rrn;
    logic              spec;  // speculative tag
  } issue_slot_t;

  typedef struct packed {
    logic              valid;
    logic [reg_w-1:0]  arn;
    logic [reg_w-1:0]  rrn;
    logic [data_w-1:0] data;
  } cdb_t;

  typedef struct packed {
    alu_op_e           op;
    logic [reg_w-1:0]  src1;
    logic [reg_w-1:0]  src2;
    logic              valid1;
    logic              valid2;
    logic [data_w-1:0] data1;
    logic [data_w-1:0] data2;
    logic [imm_w-1:0]  imm;
    logic [reg_w-1:0]  dest_arn;
    logic [reg_w-1:0]  dest_rrn;
    logic              spec;
    logic              ignore;  // flushed, leaves without executing
  } station_rec_t;

  typedef struct packed {
    logic              valid;
    alu_op_e           op;
    logic [data_w-1:0] data1;
    logic [data_w-1:0] data2;
    logic [imm_w-1:0]  imm;
    logic [reg_w-1:0]  dest_arn;
    logic [reg_w-1:0]  dest_rrn;
  } exec_feed_t;

  function automatic logic cdb_hit(input logic [reg_w-1:0] src, input cdb_t bus);
    return bus.valid && (src != '0) && ((src == bus.arn) || (src == bus.rrn));
  endfunction

  // returns {valid, data}, port a wins over port b
  function automatic logic [data_w:0] capture_operand(
    input logic              have,
    input logic [data_w-1:0] data,
    input logic [reg_w-1:0]  src,
    input cdb_t              bus_a,
    input cdb_t              bus_b
  );
    if (have) return {1'b1, data};
    if (cdb_hit(src, bus_a)) return {1'b1, bus_a.data};
    if (cdb_hit(src, bus_b)) return {1'b1, bus_b.data};
    return {1'b0, data};
  endfunction

endpackage

`default_nettype wire

// File: design/operand_capture.sv
`timescale 1ns/10ps
`default_nettype none

module operand_capture
  import station_pkg::*;
(
  input  issue_slot_t  slot,
  input  cdb_t         cdb_a,
  input  cdb_t         cdb_b,
  output station_rec_t rec
);

  always_comb begin
    rec.op       = slot.op;
    rec.src1     = slot.src1;
    rec.src2     = slot.src2;
    rec.imm      = slot.imm;
    rec.dest_arn = slot.dest_arn;
    rec.dest_rrn = slot.dest_rrn;
    rec.spec     = slot.spec;
    rec.ignore   = 1'b0;

    // a broadcast during the issue cycle must not be missed
    {rec.valid1, rec.data1} = capture_operand(slot.ready1, slot.data1, slot.src1,
                                              cdb_a, cdb_b);
    {rec.valid2, rec.data2} = capture_operand(slot.ready2, slot.data2, slot.src2,
                                              cdb_a, cdb_b);
  end

endmodule

`default_nettype wire

// File: design/reservation_station.sv
`timescale 1ns/10ps
`default_nettype none

module reservation_station
  import station_pkg::*;
#(
  parameter int depth = rs_depth
)(
  input  logic               global_signals,
  input  logic               rst_n,
  input  issue_slot_t        issue0,
  input  issue_slot_t        issue1,
  input  cdb_t               cdb_a,
  input  cdb_t               cdb_b,
  input  logic               flush,
  output exec_feed_t         exec_feed,
  output logic [space_w-1:0] free_space
);

  localparam int idx_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  station_rec_t     records [depth];
  logic [idx_w-1:0] head;
  logic [cnt_w-1:0] count;

  station_rec_t     rec0;
  station_rec_t     rec1;
  station_rec_t     head_rec;
  logic             take0;
  logic             take1;
  logic             pop;
  logic [idx_w-1:0] tail0;
  logic [idx_w-1:0] tail1;
  logic [idx_w-1:0] head_next;
  logic [cnt_w-1:0] count_next;
  exec_feed_t       feed_d;

  function automatic logic [idx_w-1:0] wrap_idx(input int pos);
    return idx_w'(pos % depth);
  endfunction

  operand_capture u_capture0 (
    .slot  (issue0),
    .cdb_a (cdb_a),
    .cdb_b (cdb_b),
    .rec   (rec0)
  );

  operand_capture u_capture1 (
    .slot  (issue1),
    .cdb_a (cdb_a),
    .cdb_b (cdb_b),
    .rec   (rec1)
  );

  assign take0 = issue0.valid && (issue0.station == alu_station) && !flush;
  assign take1 = issue1.valid && (issue1.station == alu_station) && !flush;

  assign head_rec = records[head];
  assign pop = (count != '0) && ((head_rec.valid1 && head_rec.valid2) || head_rec.ignore);

  assign tail0 = wrap_idx(int'(head) + int'(count));
  assign tail1 = wrap_idx(int'(head) + int'(count) + int'(take0));  // slot 0 goes first

  assign head_next  = pop ? wrap_idx(int'(head) + 1) : head;
  assign count_next = count + cnt_w'(take0) + cnt_w'(take1) - cnt_w'(pop);

  always_comb begin
    feed_d = '0;
    // a flush on the pop edge also kills a speculative head
    if (pop && !head_rec.ignore && !(flush && head_rec.spec)) begin
      feed_d.valid    = 1'b1;
      feed_d.op       = head_rec.op;
      feed_d.data1    = head_rec.data1;
      feed_d.data2    = head_rec.data2;
      feed_d.imm      = head_rec.imm;
      feed_d.dest_arn = head_rec.dest_arn;
      feed_d.dest_rrn = head_rec.dest_rrn;
    end
  end

  always_ff @(posedge global_signals) begin
    if (!rst_n) begin
      head            <= '0;
      count           <= '0;
      free_space      <= space_w'(depth);
      exec_feed.valid <= 1'b0;
    end else begin
      head       <= head_next;
      count      <= count_next;
      free_space <= space_w'(depth - count_next);
      exec_feed  <= feed_d;
    end
  end

  always_ff @(posedge global_signals) begin
    for (int i = 0; i < depth; i++) begin
      {records[i].valid1, records[i].data1} <=
        capture_operand(records[i].valid1, records[i].data1, records[i].src1, cdb_a, cdb_b);
      {records[i].valid2, records[i].data2} <=
        capture_operand(records[i].valid2, records[i].data2, records[i].src2, cdb_a, cdb_b);
      if (flush && records[i].spec) begin
        records[i].ignore <= 1'b1;
      end
    end
    if (take0) begin
      records[tail0] <= rec0;  // overrides snoop on a free slot
    end
    if (take1) begin
      records[tail1] <= rec1;
    end
  end

endmodule

`default_nettype wire

// File: design/exec_alu.sv
`timescale 1ns/10ps
`default_nettype none

module exec_alu
  import isa_pkg::*;
  import station_pkg::*;
(
  input  logic       global_signals,
  input  logic       rst_n,
  input  exec_feed_t feed,
  output cdb_t       result
);

  logic [data_w-1:0] value;

  assign value = alu_result(feed.op, feed.data1, feed.data2, feed.imm);

  always_ff @(posedge global_signals) begin
    if (!rst_n) begin
      result.valid <= 1'b0;
    end else begin
      result.valid <= feed.valid;  // broadcast, never stalled
      if (feed.valid) begin
        result.arn  <= feed.dest_arn;
        result.rrn  <= feed.dest_rrn;
        result.data <= value;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/rs_top.sv
`timescale 1ns/10ps
`default_nettype none

module rs_top
  import station_pkg::*;
(
  input  logic               global_signals,
  input  logic               rst_n,
  input  issue_slot_t        issue0,
  input  issue_slot_t        issue1,
  input  cdb_t               cdb_ext,
  input  logic               flush,
  output cdb_t               cdb_out,
  output logic [space_w-1:0] free_space
);

  exec_feed_t exec_feed;

  reservation_station #(
    .depth (rs_depth)
  ) u_station (
    .global_signals (global_signals),
    .rst_n          (rst_n),
    .issue0         (issue0),
    .issue1         (issue1),
    .cdb_a          (cdb_out),  // own result wakes dependents
    .cdb_b          (cdb_ext),
    .flush          (flush),
    .exec_feed      (exec_feed),
    .free_space     (free_space)
  );

  exec_alu u_alu (
    .global_signals (global_signals),
    .rst_n          (rst_n),
    .feed           (exec_feed),
    .result         (cdb_out)
  );

endmodule

`default_nettype wire

// File: bench/rs_top_props.sv
`timescale 1ns/10ps
`default_nettype none

module rs_top_props
  import station_pkg::*;
(
  input logic               global_signals,
  input logic               rst_n,
  input issue_slot_t        issue0,
  input issue_slot_t        issue1,
  input logic               flush,
  input cdb_t               cdb_out,
  input logic [space_w-1:0] free_space
);

  int violations = 0;  // failures seen so far
  logic take0;
  logic take1;
  logic [space_w-1:0] taken;

  assign take0 = issue0.valid && (issue0.station == alu_station) && !flush;
  assign take1 = issue1.valid && (issue1.station == alu_station) && !flush;
  assign taken = space_w'(take0) + space_w'(take1);

  space_bounded: assert property (
    @(posedge global_signals) disable iff (!rst_n) free_space <= space_w'(rs_depth)
  ) else begin
    violations++;
    $error("free_space above station depth");
  end

  // credits count only what was free before this edge
  issue_within_credit: assert property (
    @(posedge global_signals) disable iff (!rst_n) taken <= free_space
  ) else begin
    violations++;
    $error("more instructions taken than free_space allows");
  end

  quiet_after_reset: assert property (
    @(posedge global_signals) !rst_n |=> !cdb_out.valid
  ) else begin
    violations++;
    $error("cdb_out valid right after reset");
  end

endmodule

bind rs_top rs_top_props u_props (
  .global_signals (global_signals),
  .rst_n          (rst_n),
  .issue0         (issue0),
  .issue1         (issue1),
  .flush          (flush),
  .cdb_out        (cdb_out),
  .free_space     (free_space)
);

`default_nettype wire

// File: bench/rs_top_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rs_top_tb
  import isa_pkg::*;
  import station_pkg::*;
();

  logic               global_signals;
  logic               rst_n;
  issue_slot_t        issue0;
  issue_slot_t        issue1;
  cdb_t               cdb_ext;
  logic               flush;
  cdb_t               cdb_out;
  logic [space_w-1:0] free_space;

  logic [31:0] lfsr_state = 32'd66058;
  logic [5:0]  expected_rrn[$];  // model, oldest first
  logic [5:0]  expected_arn[$];
  logic [31:0] expected_data[$];
  int          errors = 0;
  int          checks = 0;

  rs_top uut (
    .global_signals (global_signals),
    .rst_n          (rst_n),
    .issue0         (issue0),
    .issue1         (issue1),
    .cdb_ext        (cdb_ext),
    .flush          (flush),
    .cdb_out        (cdb_out),
    .free_space     (free_space)
  );

  initial begin
    global_signals = 1'b0;
    forever #50 global_signals = ~global_signals;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [31:0] expect_value(input alu_op_e op, input logic [31:0] a,
                                               input logic [31:0] b, input logic [15:0] imm);
    case (op)
      alu_add:  return a + b;
      alu_sub:  return a - b;
      alu_and:  return a & b;
      alu_or:   return a | b;
      alu_xor:  return a ^ b;
      alu_addi: return a + {{16{imm[15]}}, imm};
      default:  return 32'h0;
    endcase
  endfunction

  // stays clear of every source number the tests wait on
  function automatic logic [5:0] arn_for(input logic [5:0] rrn);
    return rrn + 6'd13;
  endfunction

  // source 0 means the operand comes with the slot
  function automatic issue_slot_t make_slot(input alu_op_e op, input logic [5:0] src1,
      input logic [5:0] src2, input logic [31:0] d1, input logic [31:0] d2,
      input logic [15:0] imm, input logic [5:0] rrn, input logic spec);
    issue_slot_t s;
    s = '0;
    s.valid    = 1'b1;
    s.station  = alu_station;
    s.op       = op;
    s.src1     = src1;
    s.src2     = src2;
    s.ready1   = (src1 == 6'd0);
    s.ready2   = (src2 == 6'd0) || (op == alu_addi);
    s.data1    = d1;
    s.data2    = d2;
    s.imm      = imm;
    s.dest_arn = arn_for(rrn);
    s.dest_rrn = rrn;
    s.spec     = spec;
    return s;
  endfunction

  function automatic cdb_t make_cdb(input logic [5:0] arn, input logic [5:0] rrn,
                                    input logic [31:0] data);
    cdb_t c;
    c.valid = 1'b1;
    c.arn   = arn;
    c.rrn   = rrn;
    c.data  = data;
    return c;
  endfunction

  task automatic drive(input issue_slot_t s0, input issue_slot_t s1, input cdb_t ext,
                       input logic fl);
    @(negedge global_signals);
    issue0  = s0;
    issue1  = s1;
    cdb_ext = ext;
    flush   = fl;
  endtask

  task automatic idle();
    drive('0, '0, '0, 1'b0);
  endtask

  task automatic expect_result(input logic [5:0] rrn, input logic [31:0] data);
    expected_rrn.push_back(rrn);
    expected_arn.push_back(arn_for(rrn));
    expected_data.push_back(data);
  endtask

  task automatic check_space(input int value);
    assert (free_space == space_w'(value)) else begin
      $display("FAIL free_space got %h expected %h", free_space, space_w'(value));
      errors++;
    end
  endtask

  task automatic wait_space(input int value);
    int cycles;
    cycles = 0;
    while (free_space != space_w'(value) && cycles < 100) begin
      @(negedge global_signals);
      cycles++;
    end
    if (free_space != space_w'(value)) begin
      $display("timeout: free_space stuck at %0d while waiting for %0d", free_space, value);
      errors++;
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (expected_rrn.size() != 0 && cycles < 200) begin
      @(posedge global_signals);  // model pops on the falling edge
      cycles++;
    end
    if (expected_rrn.size() != 0) begin
      $display("timeout: %0d results never appeared on cdb_out", expected_rrn.size());
      errors++;
      expected_rrn.delete();
      expected_arn.delete();
      expected_data.delete();
    end
  endtask

  task automatic report_test(input int num, input string name, input int start_errors);
    $display("test %0d %s: %s, %0d errors", num, name,
             (errors == start_errors) ? "pass" : "fail", errors - start_errors);
  endtask

  always @(negedge global_signals) begin
    if (rst_n && cdb_out.valid) begin
      checks++;
      assert (expected_rrn.size() != 0) else begin
        $display("result for register %0d on cdb_out with nothing outstanding", cdb_out.rrn);
        errors++;
      end
      if (expected_rrn.size() != 0) begin
        assert (cdb_out.rrn == expected_rrn[0]) else begin
          $display("FAIL cdb_out.rrn got %h expected %h", cdb_out.rrn, expected_rrn[0]);
          errors++;
        end
        assert (cdb_out.arn == expected_arn[0]) else begin
          $display("FAIL cdb_out.arn got %h expected %h", cdb_out.arn, expected_arn[0]);
          errors++;
        end
        assert (cdb_out.data == expected_data[0]) else begin
          $display("FAIL cdb_out.data got %h expected %h", cdb_out.data, expected_data[0]);
          errors++;
        end
        void'(expected_rrn.pop_front());
        void'(expected_arn.pop_front());
        void'(expected_data.pop_front());
      end
    end
  end

  initial begin
    issue_slot_t s0;
    issue_slot_t s1;
    alu_op_e     op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ra;
    logic [31:0] rb;
    logic [31:0] bits;
    logic [15:0] imm;
    int          start_errors;

    rst_n   = 1'b0;
    issue0  = '0;
    issue1  = '0;
    cdb_ext = '0;
    flush   = 1'b0;
    repeat (5) @(posedge global_signals);
    @(negedge global_signals);
    rst_n = 1'b1;

    start_errors = errors;
    check_space(16);
    for (int i = 0; i < 3; i++) begin
      s0 = make_slot(alu_add, 6'd63, 6'd62, '0, '0, '0, 6'(20 + 2 * i), 1'b1);  // never ready
      s1 = make_slot(alu_sub, 6'd61, 6'd0, '0, '0, '0, 6'(21 + 2 * i), 1'b1);
      drive(s0, s1, '0, 1'b0);
    end
    idle();
    check_space(10);
    drive('0, '0, '0, 1'b1);  // flush clears the stuck entries
    idle();
    wait_space(16);
    report_test(1, "free space count", start_errors);

    start_errors = errors;
    for (int i = 0; i < 4; i++) begin
      draw_bits(32, a);
      draw_bits(32, b);
      draw_bits(1, bits);
      s0 = make_slot(alu_op_e'(3'(i)), 6'd0, 6'd0, a, b, '0, 6'(1 + 2 * i), bits[0]);
      expect_result(6'(1 + 2 * i), expect_value(alu_op_e'(3'(i)), a, b, '0));
      draw_bits(32, a);
      draw_bits(32, b);
      draw_bits(1, bits);
      s1 = make_slot(alu_op_e'(3'(i + 1)), 6'd0, 6'd0, a, b, '0, 6'(2 + 2 * i), bits[0]);
      expect_result(6'(2 + 2 * i), expect_value(alu_op_e'(3'(i + 1)), a, b, '0));
      drive(s0, s1, '0, 1'b0);
    end
    idle();
    wait_drain();
    report_test(2, "ready pairs in order", start_errors);

    start_errors = errors;
    draw_bits(32, a);
    draw_bits(32, b);
    s0 = make_slot(alu_xor, 6'd40, 6'd0, '0, b, '0, 6'd9, 1'b0);
    expect_result(6'd9, expect_value(alu_xor, a, b, '0));
    drive(s0, '0, '0, 1'b0);
    idle();
    idle();
    drive('0, '0, make_cdb(6'd40, 6'd50, a), 1'b0);  // match on arn
    draw_bits(32, a);
    draw_bits(32, b);
    s0 = make_slot(alu_sub, 6'd0, 6'd41, a, '0, '0, 6'd10, 1'b0);
    expect_result(6'd10, expect_value(alu_sub, a, b, '0));
    drive(s0, '0, make_cdb(6'd52, 6'd41, b), 1'b0);  // same cycle as issue
    idle();
    wait_drain();
    report_test(3, "wake up from cdb_ext", start_errors);

    start_errors = errors;
    draw_bits(32, a);
    draw_bits(32, b);
    ra = expect_value(alu_add, a, b, '0);
    s0 = make_slot(alu_add, 6'd0, 6'd0, a, b, '0, 6'd11, 1'b0);
    draw_bits(32, b);
    rb = expect_value(alu_and, ra, b, '0);
    s1 = make_slot(alu_and, 6'd11, 6'd0, '0, b, '0, 6'd12, 1'b0);
    expect_result(6'd11, ra);
    expect_result(6'd12, rb);
    expect_result(6'd13, expect_value(alu_or, rb, ra, '0));
    drive(s0, s1, '0, 1'b0);
    s0 = make_slot(alu_or, 6'd12, 6'd11, '0, '0, '0, 6'd13, 1'b0);
    drive(s0, '0, '0, 1'b0);
    idle();
    wait_drain();
    report_test(4, "wake up from cdb_out", start_errors);

    start_errors = errors;
    draw_bits(32, a);
    draw_bits(32, b);
    s0 = make_slot(alu_add, 6'd42, 6'd0, '0, b, '0, 6'd14, 1'b0);
    s1 = make_slot(alu_sub, 6'd0, 6'd0, a, b, '0, 6'd15, 1'b1);
    expect_result(6'd14, expect_value(alu_add, a, b, '0));
    drive(s0, s1, '0, 1'b0);
    s0 = make_slot(alu_xor, 6'd0, 6'd0, b, a, '0, 6'd16, 1'b0);
    s1 = make_slot(alu_or, 6'd43, 6'd0, '0, a, '0, 6'd17, 1'b1);
    expect_result(6'd16, expect_value(alu_xor, b, a, '0));
    drive(s0, s1, '0, 1'b0);
    s0 = make_slot(alu_add, 6'd0, 6'd0, a, b, '0, 6'd18, 1'b1);  // offered during flush
    s1 = make_slot(alu_add, 6'd0, 6'd0, a, b, '0, 6'd19, 1'b0);
    drive(s0, s1, '0, 1'b1);
    idle();
    drive('0, '0, make_cdb(6'd53, 6'd42, a), 1'b0);
    idle();
    wait_drain();
    wait_space(16);
    report_test(5, "flush of tagged entries", start_errors);

    start_errors = errors;
    for (int i = 0; i < 8; i++) begin
      op = (i < 6) ? alu_op_e'(3'(i)) : alu_addi;
      draw_bits(32, a);
      draw_bits(32, b);
      draw_bits(16, bits);
      imm = bits[15:0];
      if (op == alu_addi) begin
        imm[15] = 1'b1;  // negative immediate
      end
      expect_result(6'(1 + i), expect_value(op, a, b, imm));
      if (i % 2 == 0) begin
        s0 = make_slot(op, 6'd0, 6'd0, a, b, imm, 6'(1 + i), 1'b0);
      end else begin
        s1 = make_slot(op, 6'd0, 6'd0, a, b, imm, 6'(1 + i), 1'b0);
        drive(s0, s1, '0, 1'b0);
      end
    end
    idle();
    wait_drain();
    report_test(6, "opcode results", start_errors);

    $display("results checked %0d, errors %0d, assertion failures %0d",
             checks, errors, uut.u_props.violations);
    if (errors == 0 && uut.u_props.violations == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
design/isa_pkg.sv
design/station_pkg.sv
design/operand_capture.sv
design/reservation_station.sv
design/exec_alu.sv
design/rs_top.sv
bench/rs_top_props.sv
bench/rs_top_tb.sv

// File: Bender.yml
package:
  name: rs_top

sources:
  - files:
      - design/isa_pkg.sv
      - design/station_pkg.sv
      - design/operand_capture.sv
      - design/reservation_station.sv
      - design/exec_alu.sv
      - design/rs_top.sv
  - target: test
    files:
      - bench/rs_top_props.sv
      - bench/rs_top_tb.sv
